//--- src.f
+incdir+verilog
verilog/asg_pkg.sv
verilog/asg_reg_pkg.sv
verilog/asg_regs.sv
verilog/asg_trig.sv
verilog/asg_core.sv
verilog/asg_out.sv
verilog/asg_top.sv
tests/asg_tb.sv

//--- Makefile
# Verilator build and run for the signal generator testbench

VERILATOR ?= verilator
TOP       ?= asg_tb
SEED      ?= 1
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(filter-out +incdir+%,$(shell cat src.f))
HDRS := $(wildcard verilog/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): src.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f src.f --top-module $(TOP) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- tests/asg_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the signal generator top level
// clock and reset, LCG stimulus, table/pointer/burst/gain model
// register read-back, continuous, burst, scaling and trigger tests
////////////////////////////////////////////////////////////////////////////

`include "asg_defines.svh"

module asg_tb import asg_pkg::*, asg_reg_pkg::*; ();

  localparam int MAX_CYC = 20000;  // all tests with a wide margin

  logic                clk;
  logic                ctl_rst;
  logic                bus_ena;
  logic                bus_wen;
  logic [`ASG_BAW-1:0] bus_addr;
  logic [`ASG_BDW-1:0] bus_wdata;
  logic [`ASG_BDW-1:0] bus_rdata;
  logic                ext_trg;
  logic [`ASG_DWO-1:0] dac_dat;
  logic                dac_vld;
  logic                trg_out;

  // reference model state
  logic [`ASG_DWO-1:0] tbl_mdl [2**`ASG_CWM];
  logic [`ASG_PW-1:0]  m_size, m_step, m_offs;
  logic [`ASG_GW-1:0]  m_gain;
  logic [`ASG_DWO-1:0] m_dcoff;
  logic [`ASG_DWO-1:0] exp_q [$];   // expected dac_dat, in order

  logic [31:0] seed = 32'h390a;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          test_bad = 0;
  int          trg_seen = 0;        // trg_out high cycles
  int          cyc_cnt = 0;

  asg_top u_dut (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= MAX_CYC) begin
      $display("timeout: run stopped after %0d cycles", cyc_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;  // plain LCG
    return seed;
  endfunction

  function automatic logic [31:0] field_mask(input int width);
    return (width >= 32) ? 32'hffff_ffff : (32'd1 << width) - 32'd1;
  endfunction

  // sample * gain >>> GFW + offset, clamped to the DAC range
  function automatic logic [`ASG_DWO-1:0] scale_sample(input logic [`ASG_DWO-1:0] s);
    longint p;
    longint hi;
    longint lo;
    hi = (longint'(1) << (`ASG_DWO - 1)) - 1;
    lo = -(longint'(1) << (`ASG_DWO - 1));
    p = longint'($signed(s)) * longint'($signed(m_gain));
    p = p >>> `ASG_GFW;
    p = p + longint'($signed(m_dcoff));
    if (p > hi) p = hi;
    else if (p < lo) p = lo;
    return p[`ASG_DWO-1:0];
  endfunction

  // pointer step with single wrap past the size
  function automatic logic [`ASG_PW-1:0] next_ptr(input logic [`ASG_PW-1:0] p);
    logic [`ASG_PW:0] sum;
    logic [`ASG_PW:0] wrap;
    sum  = {1'b0, p} + {1'b0, m_step};
    wrap = sum - {1'b0, m_size} - 1'b1;
    return (sum > {1'b0, m_size}) ? wrap[`ASG_PW-1:0] : sum[`ASG_PW-1:0];
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;  // drive and sample just after the edge
  endtask

  task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] got);
    $display("ERROR %s expected %h got %h (cycle %0d)", sig, exp, got, cyc_cnt);
    err_cnt++;
  endtask

  task automatic fail_note(input string msg);
    $display("%s (cycle %0d)", msg, cyc_cnt);
    err_cnt++;
  endtask

  task automatic end_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      test_bad++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
    end
  endtask

  task automatic bus_write(input logic [`ASG_BAW-1:0] addr, input logic [31:0] data);
    bus_ena   = 1'b1;
    bus_wen   = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    tick();
    bus_ena = 1'b0;
    bus_wen = 1'b0;
  endtask

  // fixed one-cycle read latency
  task automatic bus_read(input logic [`ASG_BAW-1:0] addr, output logic [31:0] data);
    bus_ena  = 1'b1;
    bus_wen  = 1'b0;
    bus_addr = addr;
    tick();
    bus_ena = 1'b0;
    data    = bus_rdata;
  endtask

  task automatic check_idle_status();
    logic [31:0] rd;
    bus_read(REG_STATUS, rd);
    if (rd !== {30'b0, ST_IDLE}) value_error("bus_rdata status", {30'b0, ST_IDLE}, rd);
  endtask

  // random entries at indices 0..n-1
  task automatic fill_table(input int n);
    logic [31:0] r;
    logic [6:0]  idx;
    for (int i = 0; i < n; i++) begin
      r   = next_rand();
      idx = i[6:0];
      bus_write({1'b1, idx}, r);
      tbl_mdl[idx] = r[`ASG_DWO-1:0];
    end
  endtask

  // size under 64 entries, fractional step no larger than the size
  task automatic pick_wave();
    logic [31:0] r;
    logic [5:0]  n;
    r      = next_rand();
    n      = 6'd1 + r[5:0] % 6'd62;
    m_size = {{(`ASG_CWM-6){1'b0}}, n, {`ASG_CWF{1'b1}}};
    r      = next_rand();
    m_step = `ASG_PW'(32'd1 + r % {6'b0, m_size});
    r      = next_rand();
    m_offs = `ASG_PW'(r % ({6'b0, m_size} + 32'd1));
    bus_write(REG_SIZE, {6'b0, m_size});
    bus_write(REG_STEP, {6'b0, m_step});
    bus_write(REG_OFFS, {6'b0, m_offs});
  endtask

  task automatic set_scale(input logic [`ASG_GW-1:0] g, input logic [`ASG_DWO-1:0] o);
    m_gain  = g;
    m_dcoff = o;
    bus_write(REG_GAIN, {16'b0, g});
    bus_write(REG_DCOFF, {18'b0, o});
  endtask

  // one run of n samples from the start phase
  task automatic queue_run(input int n);
    logic [`ASG_PW-1:0] p;
    p = m_offs;
    repeat (n) begin
      exp_q.push_back(scale_sample(tbl_mdl[p[`ASG_PW-1:`ASG_CWF]]));
      p = next_ptr(p);
    end
  endtask

  // compare n valid samples with the queue, idle cycles show the offset
  task automatic check_stream(input int n, input int limit, input bit toggle_ext);
    int got;
    int waited;
    logic [`ASG_DWO-1:0] exp;
    got    = 0;
    waited = 0;
    while (got < n && waited < limit) begin
      tick();
      waited++;
      if (trg_out) trg_seen++;
      if (dac_vld) begin
        exp = exp_q.pop_front();
        if (dac_dat !== exp) value_error("dac_dat", exp, dac_dat);
        got++;
      end else if (dac_dat !== m_dcoff) begin
        value_error("dac_dat idle", m_dcoff, dac_dat);
      end
      if (toggle_ext && waited % 5 == 0) ext_trg = ~ext_trg;  // edges while running
    end
    if (got < n) fail_note($sformatf("missing samples: %0d of %0d within %0d cycles",
                                     got, n, limit));
  endtask

  task automatic expect_quiet(input int n, input bit toggle_ext);
    for (int k = 1; k <= n; k++) begin
      tick();
      if (trg_out) trg_seen++;
      if (dac_vld) fail_note("dac_vld high while the generator should be idle");
      else if (dac_dat !== m_dcoff) value_error("dac_dat idle", m_dcoff, dac_dat);
      if (toggle_ext && k % 3 == 0) ext_trg = ~ext_trg;
    end
  endtask

  // clear, then in-flight samples must be gone within three cycles
  task automatic stop_and_drain();
    int n;
    bus_write(REG_CTRL, 32'd1 << CTRL_CLR_BIT);
    tick();  // clear reaches the FSM
    n = 0;
    while (dac_vld && n < 3) begin
      tick();
      n++;
    end
    if (dac_vld) fail_note("dac_vld still high three cycles after software clear");
    exp_q.delete();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_regs();
    logic [`ASG_BAW-1:0] addrs [10];
    int                  widths [10];
    logic [31:0]         vals [10];
    logic [31:0]         rd;
    logic [31:0]         r;
    logic [6:0]          idx;
    logic [6:0]          idx_q [$];
    int                  e0;
    e0 = err_cnt;
    if (dac_vld !== 1'b0) value_error("dac_vld", 0, dac_vld);  // reset values
    if (trg_out !== 1'b0) value_error("trg_out", 0, trg_out);
    if (dac_dat !== '0) value_error("dac_dat", 0, dac_dat);
    addrs  = '{REG_TRGSEL, REG_SIZE, REG_STEP, REG_OFFS, REG_BURST,
               REG_BCYC, REG_BDLY, REG_BNUM, REG_GAIN, REG_DCOFF};
    widths = '{2, `ASG_PW, `ASG_PW, `ASG_PW, 2, `ASG_CNW, `ASG_BDW, `ASG_CNW,
               `ASG_GW, `ASG_DWO};
    for (int i = 0; i < 10; i++) begin
      vals[i] = next_rand();
      if (addrs[i] == REG_TRGSEL) vals[i] = vals[i] % 3;  // legal sources only
      bus_write(addrs[i], vals[i]);
      vals[i] = vals[i] & field_mask(widths[i]);
    end
    for (int i = 0; i < 10; i++) begin
      bus_read(addrs[i], rd);
      if (rd !== vals[i]) value_error($sformatf("bus_rdata reg %h", addrs[i]), vals[i], rd);
    end
    repeat (64) begin
      r   = next_rand();
      idx = r[22:16];
      bus_write({1'b1, idx}, r);
      tbl_mdl[idx] = r[`ASG_DWO-1:0];
      idx_q.push_back(idx);
    end
    foreach (idx_q[i]) begin
      bus_read({1'b1, idx_q[i]}, rd);
      if (rd !== {18'b0, tbl_mdl[idx_q[i]]})
        value_error($sformatf("bus_rdata tbl %0d", idx_q[i]), {18'b0, tbl_mdl[idx_q[i]]}, rd);
    end
    check_idle_status();
    end_test("register and table read-back", e0);
  endtask

  task automatic test_continuous();
    int e0;
    e0 = err_cnt;
    fill_table(64);
    bus_write(REG_TRGSEL, 32'(TRG_SW));
    bus_write(REG_BURST, 32'd0);
    set_scale(`ASG_GW'(1) << `ASG_GFW, '0);  // unity gain
    pick_wave();
    exp_q.delete();
    queue_run(200);
    bus_write(REG_CTRL, 32'd1 << CTRL_TRG_BIT);
    check_stream(200, 240, 1'b0);
    stop_and_drain();
    check_idle_status();
    end_test("continuous mode", e0);
  endtask

  task automatic test_burst();
    logic [31:0] r;
    int          bcyc;
    int          bdly;
    int          bnum;
    int          e0;
    e0   = err_cnt;
    r    = next_rand();
    bcyc = r[7:0] % 6;
    bdly = r[15:8] % 5;
    bnum = 1 + r[23:16] % 4;
    pick_wave();
    bus_write(REG_BCYC, 32'(bcyc));
    bus_write(REG_BDLY, 32'(bdly));
    bus_write(REG_BNUM, 32'(bnum));
    bus_write(REG_BURST, 32'd1);
    exp_q.delete();
    repeat (bnum) queue_run(bcyc + 1);  // each burst restarts at the offset
    trg_seen = 0;
    bus_write(REG_CTRL, 32'd1 << CTRL_TRG_BIT);
    check_stream(bnum * (bcyc + 1), bnum * (bcyc + 1 + bdly) + 20, 1'b0);
    expect_quiet(12, 1'b0);
    if (trg_seen != bnum) value_error("trg_out pulses", bnum, trg_seen);
    check_idle_status();
    end_test("burst mode", e0);
  endtask

  task automatic test_gain();
    logic [31:0] r;
    int          e0;
    e0 = err_cnt;
    fill_table(64);
    bus_write(REG_BURST, 32'd0);
    pick_wave();
    r = next_rand();
    set_scale(r[15:0], r[29:16]);  // full signed range, saturates often
    exp_q.delete();
    queue_run(150);
    expect_quiet(4, 1'b0);
    bus_write(REG_CTRL, 32'd1 << CTRL_TRG_BIT);
    check_stream(150, 190, 1'b0);
    stop_and_drain();
    expect_quiet(4, 1'b0);
    end_test("gain, offset and saturation", e0);
  endtask

  task automatic test_ext();
    int e0;
    e0 = err_cnt;
    bus_write(REG_BURST, 32'd0);
    set_scale(`ASG_GW'(1) << `ASG_GFW, '0);
    pick_wave();
    bus_write(REG_TRGSEL, 32'(TRG_EXT_RISE));
    exp_q.delete();
    queue_run(80);
    trg_seen = 0;
    ext_trg  = 1'b1;  // the starting edge
    check_stream(80, 120, 1'b1);
    if (trg_seen != 1) value_error("trg_out pulses", 1, trg_seen);
    ext_trg = 1'b0;
    repeat (4) tick();  // let the pin settle through the synchroniser
    stop_and_drain();
    check_idle_status();
    bus_write(REG_TRGSEL, 32'(TRG_SW));
    trg_seen = 0;
    expect_quiet(40, 1'b1);  // pin masked now
    if (trg_seen != 0) value_error("trg_out pulses", 0, trg_seen);
    ext_trg = 1'b0;
    end_test("external trigger and clear", e0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    ctl_rst   = 1'b1;
    bus_ena   = 1'b0;
    bus_wen   = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    ext_trg   = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    ctl_rst = 1'b0;
    test_regs();
    test_continuous();
    test_burst();
    test_gain();
    test_ext();
    $display("tests run %0d, failed %0d, errors %0d", test_cnt, test_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/asg_top.sv
////////////////////////////////////////////////////////////////////////////
// signal generator top level
// register decode, trigger, core and output stage
////////////////////////////////////////////////////////////////////////////

`include "asg_defines.svh"

module asg_top import asg_pkg::*; (
  input  logic                        clk,
  input  logic                        ctl_rst,
  input  logic                        bus_ena,
  input  logic                        bus_wen,
  input  logic [`ASG_BAW-1:0]         bus_addr,
  input  logic [`ASG_BDW-1:0]         bus_wdata,
  output logic [`ASG_BDW-1:0]         bus_rdata,
  input  logic                        ext_trg,
  output logic signed [`ASG_DWO-1:0]  dac_dat,
  output logic                        dac_vld,
  output logic                        trg_out
);

  trg_src_t                   trg_sel;
  asg_state_t                 sts_state;
  logic                       sw_trg, sw_clr, trg;
  logic                       tbl_ena, tbl_wen;
  logic [`ASG_CWM-1:0]        tbl_addr;
  logic [`ASG_DWO-1:0]        tbl_wdata, tbl_rdata;
  logic [`ASG_PW-1:0]         cfg_size, cfg_step, cfg_offs;
  logic                       cfg_bena, cfg_binf;
  logic [`ASG_CNW-1:0]        cfg_bcyc, cfg_bnum;
  logic [`ASG_BDW-1:0]        cfg_bdly;
  logic signed [`ASG_GW-1:0]  cfg_gain;
  logic signed [`ASG_DWO-1:0] cfg_dcoff, smp_dat;
  logic                       smp_vld;

  asg_regs u_regs (
    .clk, .ctl_rst, .bus_ena, .bus_wen, .bus_addr, .bus_wdata, .bus_rdata,
    .tbl_rdata, .sts_state, .trg_sel, .sw_trg, .sw_clr,
    .tbl_ena, .tbl_wen, .tbl_addr, .tbl_wdata,
    .cfg_size, .cfg_step, .cfg_offs, .cfg_bena, .cfg_binf,
    .cfg_bcyc, .cfg_bdly, .cfg_bnum, .cfg_gain, .cfg_dcoff
  );

  asg_trig u_trig (.clk, .ctl_rst, .ext_trg, .trg_sel, .sw_trg, .trg);

  asg_core u_core (
    .clk, .ctl_rst, .trg, .sw_clr,
    .cfg_size, .cfg_step, .cfg_offs, .cfg_bena, .cfg_binf,
    .cfg_bcyc, .cfg_bdly, .cfg_bnum,
    .tbl_ena, .tbl_wen, .tbl_addr, .tbl_wdata, .tbl_rdata,
    .sts_state, .smp_dat, .smp_vld, .trg_out
  );

  asg_out u_out (.clk, .ctl_rst, .smp_dat, .smp_vld, .cfg_gain, .cfg_dcoff, .dac_dat, .dac_vld);

endmodule

//--- verilog/asg_out.sv
////////////////////////////////////////////////////////////////////////////
// output stage
// signed gain, DC offset, clamp to DAC range, output register
////////////////////////////////////////////////////////////////////////////

`include "asg_defines.svh"

module asg_out (
  input  logic                        clk,
  input  logic                        ctl_rst,
  input  logic signed [`ASG_DWO-1:0]  smp_dat,
  input  logic                        smp_vld,
  input  logic signed [`ASG_GW-1:0]   cfg_gain,   // ASG_GFW fraction bits
  input  logic signed [`ASG_DWO-1:0]  cfg_dcoff,
  output logic signed [`ASG_DWO-1:0]  dac_dat,
  output logic                        dac_vld
);

  localparam int SCW = `ASG_DWO + `ASG_GW - `ASG_GFW;  // scaled width
  localparam logic signed [`ASG_DWO-1:0] DAC_MAX = {1'b0, {(`ASG_DWO-1){1'b1}}};
  localparam logic signed [`ASG_DWO-1:0] DAC_MIN = {1'b1, {(`ASG_DWO-1){1'b0}}};

  logic signed [`ASG_DWO+`ASG_GW-1:0] mul;
  logic signed [SCW-1:0]              scl;   // after the >>> GFW
  logic signed [SCW:0]                sum;   // room for the offset carry
  logic                               ovf;

  assign mul = smp_dat * cfg_gain;
  assign scl = smp_vld ? $signed(mul[`ASG_GFW +: SCW]) : '0;  // idle shows offset only
  assign sum = scl + cfg_dcoff;
  // out of range unless all bits above the DAC sign agree
  assign ovf = |sum[SCW:`ASG_DWO-1] && !(&sum[SCW:`ASG_DWO-1]);

  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      dac_dat <= '0;
      dac_vld <= 1'b0;
    end else begin
      dac_dat <= !ovf ? sum[`ASG_DWO-1:0] : (sum[SCW] ? DAC_MIN : DAC_MAX);
      dac_vld <= smp_vld;
    end
  end

  // full-width sum beyond the DAC range must land on the matching limit
  a_clamp_hi: assert property (@(posedge clk) disable iff (ctl_rst)
    sum > DAC_MAX |=> dac_dat == DAC_MAX);
  a_clamp_lo: assert property (@(posedge clk) disable iff (ctl_rst)
    sum < DAC_MIN |=> dac_dat == DAC_MIN);

endmodule

//--- verilog/asg_core.sv
////////////////////////////////////////////////////////////////////////////
// generator core
// waveform table RAM with bus port, fixed-point pointer with modulo wrap,
// burst FSM and the stream read pipeline
////////////////////////////////////////////////////////////////////////////

`include "asg_defines.svh"

module asg_core import asg_pkg::*; (
  input  logic                        clk,
  input  logic                        ctl_rst,
  input  logic                        trg,        // start request pulse
  input  logic                        sw_clr,     // abort to idle
  input  logic [`ASG_PW-1:0]          cfg_size,   // table size - 1, fixed point
  input  logic [`ASG_PW-1:0]          cfg_step,
  input  logic [`ASG_PW-1:0]          cfg_offs,   // start phase
  input  logic                        cfg_bena,
  input  logic                        cfg_binf,
  input  logic [`ASG_CNW-1:0]         cfg_bcyc,   // samples per burst - 1
  input  logic [`ASG_BDW-1:0]         cfg_bdly,   // gap cycles
  input  logic [`ASG_CNW-1:0]         cfg_bnum,   // burst count
  input  logic                        tbl_ena,
  input  logic                        tbl_wen,
  input  logic [`ASG_CWM-1:0]         tbl_addr,
  input  logic [`ASG_DWO-1:0]         tbl_wdata,
  output logic [`ASG_DWO-1:0]         tbl_rdata,
  output asg_state_t                  sts_state,
  output logic signed [`ASG_DWO-1:0]  smp_dat,
  output logic                        smp_vld,
  output logic                        trg_out     // burst start event
);

  logic [`ASG_DWO-1:0] tbl_mem [2**`ASG_CWM];

  asg_state_t          state;
  logic [`ASG_PW-1:0]  ptr;
  logic [`ASG_PW:0]    ptr_sum;   // one carry bit
  logic [`ASG_PW+1:0]  ptr_sub;   // sum - size - 1, sign on top
  logic [`ASG_CNW-1:0] cyc_cnt;
  logic [`ASG_BDW-1:0] dly_cnt;
  logic [`ASG_CNW-1:0] rep_cnt;   // bursts left incl. current
  logic                burst_end;
  logic                start;
  logic [`ASG_CWM-1:0] rd_addr;
  logic                rd_act;

  //////////////////////////////////////////////////////////////////////////
  // table RAM
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (tbl_ena && tbl_wen) tbl_mem[tbl_addr] <= tbl_wdata;
    if (tbl_ena && !tbl_wen) tbl_rdata <= tbl_mem[tbl_addr];
  end

  // stream side, address stage then RAM stage
  always_ff @(posedge clk) begin
    rd_addr <= ptr[`ASG_CWF +: `ASG_CWM];  // integer part
    if (rd_act) smp_dat <= tbl_mem[rd_addr];
  end

  //////////////////////////////////////////////////////////////////////////
  // burst FSM
  //////////////////////////////////////////////////////////////////////////

  // delay state always has cyc_cnt at zero
  assign burst_end = cfg_bena && state != ST_IDLE && cyc_cnt == '0 && dly_cnt == '0;
  // idle trigger, or chain into the next burst
  assign start = (trg && state == ST_IDLE) || (burst_end && (cfg_binf || rep_cnt > 1));

  always_ff @(posedge clk) begin
    if (ctl_rst || sw_clr) begin
      state   <= ST_IDLE;
      cyc_cnt <= '0;
      dly_cnt <= '0;
      rep_cnt <= '0;
    end else if (start) begin
      state   <= ST_DATA;
      cyc_cnt <= cfg_bcyc;
      dly_cnt <= cfg_bdly;
      rep_cnt <= (state == ST_IDLE) ? cfg_bnum : rep_cnt - 1'b1;
    end else if (burst_end) begin
      state <= ST_IDLE;  // last burst done
    end else if (cfg_bena && state != ST_IDLE) begin
      if (cyc_cnt != '0) begin
        cyc_cnt <= cyc_cnt - 1'b1;
      end else if (dly_cnt != '0) begin
        state   <= ST_DELAY;  // counts its first gap cycle here
        dly_cnt <= dly_cnt - 1'b1;
      end
    end
  end

  assign sts_state = state;

  //////////////////////////////////////////////////////////////////////////
  // read pointer
  //////////////////////////////////////////////////////////////////////////

  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg_step};
  assign ptr_sub = {1'b0, ptr_sum} - {2'b00, cfg_size} - 1'b1;

  always_ff @(posedge clk) begin
    if (start) ptr <= cfg_offs;  // every burst restarts the phase
    else if (state == ST_DATA) ptr <= ptr_sub[`ASG_PW+1] ? ptr_sum[`ASG_PW-1:0] :
                                                          ptr_sub[`ASG_PW-1:0];
  end

  // valid pipeline ignores sw_clr, samples in flight drain
  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      rd_act  <= 1'b0;
      smp_vld <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      rd_act  <= state == ST_DATA;
      smp_vld <= rd_act;
      trg_out <= start && !sw_clr;
    end
  end

  a_state_enc: assert property (@(posedge clk) disable iff (ctl_rst)
    state inside {ST_IDLE, ST_DATA, ST_DELAY});
  a_rst_vld: assert property (@(posedge clk) ctl_rst |=> !smp_vld);

endmodule

//--- verilog/asg_trig.sv
////////////////////////////////////////////////////////////////////////////
// trigger conditioning
// ext pin synchroniser, edge select, merge with software trigger
////////////////////////////////////////////////////////////////////////////

module asg_trig import asg_pkg::*; (
  input  logic     clk,
  input  logic     ctl_rst,
  input  logic     ext_trg,   // async pin
  input  trg_src_t trg_sel,
  input  logic     sw_trg,    // already a pulse
  output logic     trg        // single-cycle start request
);

  logic [1:0] ext_sync;  // two-flop synchroniser
  logic       ext_prev;  // synced level, one cycle older
  logic       ext_edge;  // selected edge, registered
  logic       trg_q;

  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      ext_sync <= '0;
      ext_prev <= 1'b0;
      ext_edge <= 1'b0;
      trg_q    <= 1'b0;
    end else begin
      ext_sync <= {ext_sync[0], ext_trg};
      ext_prev <= ext_sync[1];
      case (trg_sel)
        TRG_EXT_RISE: ext_edge <= ext_sync[1] & ~ext_prev;
        TRG_EXT_FALL: ext_edge <= ~ext_sync[1] & ext_prev;
        default:      ext_edge <= 1'b0;  // pin masked in sw mode
      endcase
      trg_q <= trg;
    end
  end

  // sw path is combinational, adjacent requests collapse to one
  assign trg = (sw_trg | ext_edge) & ~trg_q;

  a_trg_pulse: assert property (@(posedge clk) disable iff (ctl_rst) trg |=> !trg);

endmodule

//--- verilog/asg_regs.sv
////////////////////////////////////////////////////////////////////////////
// register bus decode
// configuration registers, CTRL pulses, table window routing
// and registered read-back mux
////////////////////////////////////////////////////////////////////////////

`include "asg_defines.svh"

module asg_regs import asg_pkg::*, asg_reg_pkg::*; (
  input  logic                        clk,
  input  logic                        ctl_rst,
  input  logic                        bus_ena,    // one access per strobe
  input  logic                        bus_wen,
  input  logic [`ASG_BAW-1:0]         bus_addr,
  input  logic [`ASG_BDW-1:0]         bus_wdata,
  output logic [`ASG_BDW-1:0]         bus_rdata,  // one cycle after strobe
  input  logic [`ASG_DWO-1:0]         tbl_rdata,
  input  asg_state_t                  sts_state,
  output trg_src_t                    trg_sel,
  output logic                        sw_trg,
  output logic                        sw_clr,
  output logic                        tbl_ena,
  output logic                        tbl_wen,
  output logic [`ASG_CWM-1:0]         tbl_addr,
  output logic [`ASG_DWO-1:0]         tbl_wdata,
  output logic [`ASG_PW-1:0]          cfg_size,
  output logic [`ASG_PW-1:0]          cfg_step,
  output logic [`ASG_PW-1:0]          cfg_offs,
  output logic                        cfg_bena,
  output logic                        cfg_binf,
  output logic [`ASG_CNW-1:0]         cfg_bcyc,
  output logic [`ASG_BDW-1:0]         cfg_bdly,
  output logic [`ASG_CNW-1:0]         cfg_bnum,
  output logic signed [`ASG_GW-1:0]   cfg_gain,
  output logic signed [`ASG_DWO-1:0]  cfg_dcoff
);

  logic                tbl_hit;    // 0x80..0xFF window
  logic                reg_wr;
  logic                rd_tbl;     // read selector, one cycle late
  logic [`ASG_BDW-1:0] reg_rdata;

  assign tbl_hit = bus_addr[`ASG_BAW-1];
  assign reg_wr  = bus_ena & bus_wen & ~tbl_hit;

  // table port straight from the bus, index is offset from 0x80
  assign tbl_ena   = bus_ena & tbl_hit;
  assign tbl_wen   = bus_wen;
  assign tbl_addr  = `ASG_CWM'(bus_addr[`ASG_BAW-2:0]);
  assign tbl_wdata = bus_wdata[`ASG_DWO-1:0];

  //////////////////////////////////////////////////////////////////////////
  // config writes
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      trg_sel   <= TRG_SW;
      cfg_size  <= '0;
      cfg_step  <= '0;
      cfg_offs  <= '0;
      cfg_bena  <= 1'b0;
      cfg_binf  <= 1'b0;
      cfg_bcyc  <= '0;
      cfg_bdly  <= '0;
      cfg_bnum  <= '0;
      cfg_gain  <= '0;
      cfg_dcoff <= '0;
    end else if (reg_wr) begin
      case (bus_addr)
        REG_TRGSEL: trg_sel   <= trg_src_t'(bus_wdata[1:0]);
        REG_SIZE:   cfg_size  <= bus_wdata[`ASG_PW-1:0];
        REG_STEP:   cfg_step  <= bus_wdata[`ASG_PW-1:0];
        REG_OFFS:   cfg_offs  <= bus_wdata[`ASG_PW-1:0];
        REG_BURST: begin
          cfg_bena <= bus_wdata[0];
          cfg_binf <= bus_wdata[1];
        end
        REG_BCYC:   cfg_bcyc  <= bus_wdata[`ASG_CNW-1:0];
        REG_BDLY:   cfg_bdly  <= bus_wdata;
        REG_BNUM:   cfg_bnum  <= bus_wdata[`ASG_CNW-1:0];
        REG_GAIN:   cfg_gain  <= bus_wdata[`ASG_GW-1:0];
        REG_DCOFF:  cfg_dcoff <= bus_wdata[`ASG_DWO-1:0];
        default: ;  // CTRL, STATUS, holes
      endcase
    end
  end

  // CTRL bits become single-cycle pulses, a back-to-back write is dropped
  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      sw_trg <= 1'b0;
      sw_clr <= 1'b0;
    end else begin
      sw_trg <= reg_wr && bus_addr == REG_CTRL && bus_wdata[CTRL_TRG_BIT] && !sw_trg;
      sw_clr <= reg_wr && bus_addr == REG_CTRL && bus_wdata[CTRL_CLR_BIT] && !sw_clr;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // read-back
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ctl_rst) rd_tbl <= 1'b0;
    else if (bus_ena && !bus_wen) rd_tbl <= tbl_hit;
  end

  always_ff @(posedge clk) begin
    if (bus_ena && !bus_wen) begin
      case (bus_addr)
        REG_TRGSEL: reg_rdata <= `ASG_BDW'(trg_sel);
        REG_SIZE:   reg_rdata <= `ASG_BDW'(cfg_size);
        REG_STEP:   reg_rdata <= `ASG_BDW'(cfg_step);
        REG_OFFS:   reg_rdata <= `ASG_BDW'(cfg_offs);
        REG_BURST:  reg_rdata <= `ASG_BDW'({cfg_binf, cfg_bena});
        REG_BCYC:   reg_rdata <= `ASG_BDW'(cfg_bcyc);
        REG_BDLY:   reg_rdata <= cfg_bdly;
        REG_BNUM:   reg_rdata <= `ASG_BDW'(cfg_bnum);
        REG_GAIN:   reg_rdata <= `ASG_BDW'($unsigned(cfg_gain));    // field bits only
        REG_DCOFF:  reg_rdata <= `ASG_BDW'($unsigned(cfg_dcoff));
        REG_STATUS: reg_rdata <= `ASG_BDW'(sts_state);
        default:    reg_rdata <= '0;
      endcase
    end
  end

  // table data arrives from the core RAM register in the same cycle
  assign bus_rdata = rd_tbl ? `ASG_BDW'(tbl_rdata) : reg_rdata;

  a_sw_trg_pulse: assert property (@(posedge clk) disable iff (ctl_rst) sw_trg |=> !sw_trg);
  a_sw_clr_pulse: assert property (@(posedge clk) disable iff (ctl_rst) sw_clr |=> !sw_clr);

endmodule

//--- verilog/asg_reg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// register map
// word addresses and CTRL command bits
////////////////////////////////////////////////////////////////////////////

`include "asg_defines.svh"

package asg_reg_pkg;

  typedef enum logic [`ASG_BAW-1:0] {
    REG_CTRL   = 8'h00,  // write-only pulses
    REG_TRGSEL = 8'h01,
    REG_SIZE   = 8'h02,
    REG_STEP   = 8'h03,
    REG_OFFS   = 8'h04,
    REG_BURST  = 8'h05,  // [0] enable, [1] infinite
    REG_BCYC   = 8'h06,
    REG_BDLY   = 8'h07,
    REG_BNUM   = 8'h08,
    REG_GAIN   = 8'h09,
    REG_DCOFF  = 8'h0A,
    REG_STATUS = 8'h0B   // read-only FSM state
  } reg_addr_t;

  localparam int CTRL_TRG_BIT = 0;  // software trigger
  localparam int CTRL_CLR_BIT = 1;  // software clear

endpackage

//--- verilog/asg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// generator types
// burst FSM state and trigger source select
////////////////////////////////////////////////////////////////////////////

package asg_pkg;

  // burst FSM, also read back through REG_STATUS
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // waiting for trigger
    ST_DATA  = 2'd1,  // streaming table samples
    ST_DELAY = 2'd2   // gap between bursts, valid low
  } asg_state_t;

  // where a start request may come from
  typedef enum logic [1:0] {
    TRG_SW       = 2'd0,  // register write only
    TRG_EXT_RISE = 2'd1,  // ext pin, rising edge
    TRG_EXT_FALL = 2'd2   // ext pin, falling edge
  } trg_src_t;

endpackage

//--- verilog/asg_defines.svh
////////////////////////////////////////////////////////////////////////////
// width macros for the signal generator
// sample, table index, pointer fraction, bus, counters and gain
////////////////////////////////////////////////////////////////////////////

`ifndef ASG_DEFINES_SVH
`define ASG_DEFINES_SVH

`define ASG_DWO 14                      // DAC sample width
`define ASG_CWM 10                      // table index width
`define ASG_CWF 16                      // pointer fraction width
`define ASG_PW  (`ASG_CWM + `ASG_CWF)   // full fixed-point pointer
`define ASG_BAW 8                       // bus address width
`define ASG_BDW 32                      // bus data width
`define ASG_CNW 16                      // burst cycle and repeat counters
`define ASG_GW  16                      // signed gain width
`define ASG_GFW 13                      // gain fraction bits

`endif
